// ==== rtl/simple_ipod_pkg.sv ====
`default_nettype none

package simple_ipod_pkg;

  // ==================================================
  // Button events and speed commands
  // ==================================================

  // Conditioned button events from the key front end
  typedef struct packed {
    logic step_up;
    logic step_down;
    logic speed_reset;
  } key_events_t;

  typedef enum logic [1:0] {
    cmd_none  = 2'd0,
    cmd_up    = 2'd1,
    cmd_down  = 2'd2,
    cmd_reset = 2'd3
  } speed_cmd_e;

  // ==================================================
  // Datapath types and constants
  // ==================================================

  // Signed offset added to the default sampling period
  typedef logic signed [15:0] speed_t;

  // Sampling period in clock cycles minus one
  typedef logic [15:0] period_t;

  // Active-low segments, a in bit 0 through g in bit 6
  typedef logic [6:0] seg_t;

  typedef logic signed [7:0] tone_sample_t;

  localparam int NUM_DIGITS = 6;
  localparam speed_t SPEED_STEP = 16'sd100;

endpackage

`default_nettype wire

// ==== rtl/key_conditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_conditioner #(
  parameter int unsigned REPEAT_TICKS = 5000000
) (
  input  wire logic                         CLK_50M,
  input  wire logic                         arst_n,
  input  wire logic [2:0]                   key_n,
  output simple_ipod_pkg::key_events_t      events
);

  localparam int unsigned CNT_W = (REPEAT_TICKS > 1) ? $clog2(REPEAT_TICKS) : 1;

  // Key bit order: 0 up, 1 down, 2 reset
  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [CNT_W-1:0] repeat_cnt;
  logic             repeat_wrap;
  logic             step_up_q;
  logic             step_down_q;

  // ==================================================
  // Two-flop synchronizer, inverted to active high
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key_n;
      key_sync <= key_meta;
    end
  end

  // ==================================================
  // Repeat interval and step pulses
  // ==================================================
  assign repeat_wrap = (repeat_cnt == CNT_W'(REPEAT_TICKS - 1));

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      repeat_cnt <= '0;
    else if (repeat_wrap)
      repeat_cnt <= '0;
    else
      repeat_cnt <= repeat_cnt + 1'b1;
  end

  // A held key only counts on the wrap cycle, so one step per interval
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      step_up_q   <= 1'b0;
      step_down_q <= 1'b0;
    end
    else
    begin
      step_up_q   <= repeat_wrap & key_sync[0];
      step_down_q <= repeat_wrap & key_sync[1];
    end
  end

  // Reset is a level straight from the synchronizer
  assign events = '{step_up: step_up_q, step_down: step_down_q, speed_reset: key_sync[2]};

endmodule

`default_nettype wire

// ==== rtl/speed_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module speed_control #(
  parameter int unsigned SAMPLE_PERIOD_DEFAULT = 12499
) (
  input  wire logic                         CLK_50M,
  input  wire logic                         arst_n,
  input  wire simple_ipod_pkg::key_events_t events,
  output simple_ipod_pkg::period_t          sample_period
);

  import simple_ipod_pkg::*;

  localparam period_t PERIOD_BASE = period_t'(SAMPLE_PERIOD_DEFAULT);

  speed_cmd_e cmd;
  speed_t     speed;

  // ==================================================
  // Command decode
  // ==================================================

  // Reset wins over up, up wins over down
  always_comb
  begin
    if (events.speed_reset)
      cmd = cmd_reset;
    else if (events.step_up)
      cmd = cmd_up;
    else if (events.step_down)
      cmd = cmd_down;
    else
      cmd = cmd_none;
  end

  // ==================================================
  // Speed register and sampling period
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      speed         <= '0;
      sample_period <= PERIOD_BASE;
    end
    else
    begin
      case (cmd)
        cmd_up:    speed <= speed + SPEED_STEP;
        cmd_down:  speed <= speed - SPEED_STEP;
        cmd_reset: speed <= '0;
        default:   speed <= speed;
      endcase
      // Same width, so the sign extension is implicit and a negative
      // speed wraps around to a shorter period
      sample_period <= PERIOD_BASE + period_t'(speed);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sample_clock_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_clock_divider (
  input  wire logic                     CLK_50M,
  input  wire logic                     arst_n,
  input  wire simple_ipod_pkg::period_t sample_period,
  output logic                          sample_tick
);

  import simple_ipod_pkg::*;

  period_t count;

  // Down-counter, one tick per sample_period+1 cycles
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count       <= '0;
      sample_tick <= 1'b0;
    end
    else if (count == '0)
    begin
      // New period is picked up here only
      count       <= sample_period;
      sample_tick <= 1'b1;
    end
    else
    begin
      count       <= count - 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hex_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_display #(
  parameter int unsigned DISPLAY_TICKS = 25000000
) (
  input  wire logic                     CLK_50M,
  input  wire logic                     arst_n,
  input  wire simple_ipod_pkg::period_t value,
  output simple_ipod_pkg::seg_t         segments [simple_ipod_pkg::NUM_DIGITS]
);

  import simple_ipod_pkg::*;

  localparam int unsigned CNT_W = (DISPLAY_TICKS > 1) ? $clog2(DISPLAY_TICKS) : 1;
  localparam int DIGIT_BITS = 4 * NUM_DIGITS;

  logic [CNT_W-1:0]      refresh_cnt;
  logic                  refresh_wrap;
  logic [DIGIT_BITS-1:0] shown_value;

  function automatic seg_t hex_to_seg(input logic [3:0] nibble);
    seg_t seg;
    case (nibble)
      4'h0:    seg = 7'h40;
      4'h1:    seg = 7'h79;
      4'h2:    seg = 7'h24;
      4'h3:    seg = 7'h30;
      4'h4:    seg = 7'h19;
      4'h5:    seg = 7'h12;
      4'h6:    seg = 7'h02;
      4'h7:    seg = 7'h78;
      4'h8:    seg = 7'h00;
      4'h9:    seg = 7'h10;
      4'hA:    seg = 7'h08;
      4'hB:    seg = 7'h03;
      4'hC:    seg = 7'h46;
      4'hD:    seg = 7'h21;
      4'hE:    seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  assign refresh_wrap = (refresh_cnt == CNT_W'(DISPLAY_TICKS - 1));

  // ==================================================
  // Refresh counter and value latch
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      refresh_cnt <= '0;
      shown_value <= '0;
    end
    else if (refresh_wrap)
    begin
      refresh_cnt <= '0;
      shown_value <= DIGIT_BITS'(value);
    end
    else
      refresh_cnt <= refresh_cnt + 1'b1;
  end

  // Digit 0 holds the least significant nibble
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < NUM_DIGITS; i++)
        segments[i] <= hex_to_seg(4'h0);
    end
    else
    begin
      for (int i = 0; i < NUM_DIGITS; i++)
        segments[i] <= hex_to_seg(shown_value[4*i +: 4]);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tone_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module tone_generator #(
  parameter int unsigned TONE_HALF_PERIOD = 25000
) (
  input  wire logic                  CLK_50M,
  input  wire logic                  arst_n,
  output simple_ipod_pkg::tone_sample_t audio_sample
);

  localparam int unsigned CNT_W = (TONE_HALF_PERIOD > 1) ? $clog2(TONE_HALF_PERIOD) : 1;

  logic [CNT_W-1:0] half_cnt;
  logic             tone_level;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      half_cnt   <= '0;
      tone_level <= 1'b0;
    end
    else if (half_cnt == CNT_W'(TONE_HALF_PERIOD - 1))
    begin
      half_cnt   <= '0;
      tone_level <= ~tone_level;
    end
    else
      half_cnt <= half_cnt + 1'b1;
  end

  // High level gives +127, low level gives -128
  assign audio_sample = {~tone_level, {7{tone_level}}};

endmodule

`default_nettype wire

// ==== rtl/simple_ipod_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module simple_ipod_top #(
  parameter int unsigned REPEAT_TICKS          = 5000000,
  parameter int unsigned DISPLAY_TICKS         = 25000000,
  parameter int unsigned TONE_HALF_PERIOD      = 25000,
  parameter int unsigned SAMPLE_PERIOD_DEFAULT = 12499
) (
  input  wire logic                     CLK_50M,
  input  wire logic                     arst_n,
  input  wire logic [2:0]               key_n,
  output simple_ipod_pkg::seg_t         segments [simple_ipod_pkg::NUM_DIGITS],
  output logic                          sample_tick,
  output simple_ipod_pkg::tone_sample_t audio_sample
);

  import simple_ipod_pkg::*;

  key_events_t events;
  period_t     sample_period;

  // ==================================================
  // Speed control path
  // ==================================================
  key_conditioner #(
    .REPEAT_TICKS (REPEAT_TICKS)
  ) i_key_conditioner (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .key_n   (key_n),
    .events  (events)
  );

  speed_control #(
    .SAMPLE_PERIOD_DEFAULT (SAMPLE_PERIOD_DEFAULT)
  ) i_speed_control (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .events        (events),
    .sample_period (sample_period)
  );

  sample_clock_divider i_sample_clock_divider (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .sample_period (sample_period),
    .sample_tick   (sample_tick)
  );

  // ==================================================
  // Display and test tone
  // ==================================================
  hex_display #(
    .DISPLAY_TICKS (DISPLAY_TICKS)
  ) i_hex_display (
    .CLK_50M  (CLK_50M),
    .arst_n   (arst_n),
    .value    (sample_period),
    .segments (segments)
  );

  tone_generator #(
    .TONE_HALF_PERIOD (TONE_HALF_PERIOD)
  ) i_tone_generator (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .audio_sample (audio_sample)
  );

endmodule

`default_nettype wire

// ==== verification/simple_ipod_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module simple_ipod_asserts #(
  parameter int unsigned SAMPLE_PERIOD_DEFAULT = 12499
) (
  input wire logic                         CLK_50M,
  input wire logic                         arst_n,
  input wire simple_ipod_pkg::key_events_t events,
  input wire simple_ipod_pkg::speed_t      speed,
  input wire simple_ipod_pkg::period_t     sample_period
);

  import simple_ipod_pkg::*;

  localparam period_t PERIOD_BASE = period_t'(SAMPLE_PERIOD_DEFAULT);

  int fail_count = 0;

  // Step events are single-cycle pulses
  step_up_single: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    events.step_up |=> !events.step_up)
    else
    begin
      $error("step_up lasted two cycles");
      fail_count++;
    end

  step_down_single: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    events.step_down |=> !events.step_down)
    else
    begin
      $error("step_down lasted two cycles");
      fail_count++;
    end

  speed_cleared: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    events.speed_reset |=> (speed == '0))
    else
    begin
      $error("speed not zero after speed_reset");
      fail_count++;
    end

  // Period trails the speed register by one cycle
  period_follows_speed: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    1'b1 |=> (sample_period == PERIOD_BASE + period_t'($past(speed))))
    else
    begin
      $error("sample_period does not match default plus speed");
      fail_count++;
    end

endmodule

bind speed_control simple_ipod_asserts #(
  .SAMPLE_PERIOD_DEFAULT (SAMPLE_PERIOD_DEFAULT)
) i_simple_ipod_asserts (.*);

`default_nettype wire

// ==== verification/simple_ipod_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module simple_ipod_tb;

  import simple_ipod_pkg::*;

  localparam int REPEAT_TICKS          = 8;
  localparam int DISPLAY_TICKS         = 16;
  localparam int TONE_HALF_PERIOD      = 5;
  localparam int SAMPLE_PERIOD_DEFAULT = 200;
  localparam int TIMEOUT_CYCLES        = 20000;

  logic         CLK_50M;
  logic         arst_n;
  logic [2:0]   key_n;
  seg_t         segments [NUM_DIGITS];
  logic         sample_tick;
  tone_sample_t audio_sample;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          expected_period;
  logic [31:0] rng_state = 32'h5ee7_d011;

  // Active-low a..g patterns for hex 0 to F
  logic [6:0] seg_table [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

  simple_ipod_top #(
    .REPEAT_TICKS          (REPEAT_TICKS),
    .DISPLAY_TICKS         (DISPLAY_TICKS),
    .TONE_HALF_PERIOD      (TONE_HALF_PERIOD),
    .SAMPLE_PERIOD_DEFAULT (SAMPLE_PERIOD_DEFAULT)
  ) i_simple_ipod_top (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .key_n        (key_n),
    .segments     (segments),
    .sample_tick  (sample_tick),
    .audio_sample (audio_sample)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  always @(posedge CLK_50M)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ==================================================
  // Helpers
  // ==================================================
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Reads the six digits back as a number or -1 on an unknown pattern
  function automatic int seg_to_value();
    int value;
    int nibble;
    value = 0;
    for (int d = NUM_DIGITS - 1; d >= 0; d--)
    begin
      nibble = -1;
      for (int n = 0; n < 16; n++)
        if (segments[d] == seg_table[n])
          nibble = n;
      if (nibble < 0)
        return -1;
      value = value * 16 + nibble;
    end
    return value;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected)
    begin
      errors++;
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // Hold one key for a number of cycles, then leave a gap
  task automatic press_key(input int key, input int hold);
    @(posedge CLK_50M);
    #2 key_n[key] = 1'b0;
    repeat (hold) @(posedge CLK_50M);
    #2 key_n[key] = 1'b1;
    repeat (REPEAT_TICKS) @(posedge CLK_50M);
  endtask

  task automatic settle_display();
    repeat (2 * DISPLAY_TICKS + 4) @(posedge CLK_50M);
    @(negedge CLK_50M);
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic reset_state();
    settle_display();
    check_value("reset_state display", SAMPLE_PERIOD_DEFAULT, seg_to_value());
    checks++;
    if (audio_sample !== 8'h7F && audio_sample !== 8'h80)
    begin
      errors++;
      $display("FAIL reset_state tone: expected 7f or 80, actual %h", audio_sample);
    end
  endtask

  task automatic tone_alternation();
    tone_sample_t last;
    int           run;
    @(negedge CLK_50M);
    last = audio_sample;
    while (audio_sample == last)
      @(negedge CLK_50M);
    for (int i = 0; i < 4; i++)
    begin
      last = audio_sample;
      run = 0;
      while (audio_sample == last)
      begin
        run++;
        @(negedge CLK_50M);
      end
      check_value("tone half period", TONE_HALF_PERIOD, run);
      check_value("tone alternation", (last == 8'sh7F) ? -128 : 127, int'(audio_sample));
    end
  endtask

  task automatic speed_up_presses(input int presses);
    for (int i = 0; i < presses; i++)
      press_key(0, REPEAT_TICKS);
    expected_period = expected_period + 100 * presses;
    settle_display();
    check_value("speed_up display", expected_period, seg_to_value());
  endtask

  task automatic speed_down_and_reset(input int presses);
    for (int i = 0; i < presses; i++)
      press_key(1, REPEAT_TICKS);
    expected_period = expected_period - 100 * presses;
    settle_display();
    check_value("speed_down display", expected_period, seg_to_value());
    press_key(2, 4);
    expected_period = SAMPLE_PERIOD_DEFAULT;
    settle_display();
    check_value("speed_reset display", expected_period, seg_to_value());
  endtask

  task automatic sample_strobe_spacing();
    int spacing;
    // Skip one interval since the divider may still run on an old period
    for (int i = 0; i < 2; i++)
    begin
      @(negedge CLK_50M);
      while (!sample_tick)
        @(negedge CLK_50M);
    end
    spacing = 0;
    do
    begin
      @(negedge CLK_50M);
      spacing++;
    end
    while (!sample_tick);
    check_value("sample_tick spacing", expected_period + 1, spacing);
  endtask

  initial
  begin
    int ups;
    int downs;
    int assert_fails;
    arst_n = 1'b0;
    key_n = 3'b111;
    expected_period = SAMPLE_PERIOD_DEFAULT;
    repeat (3) @(posedge CLK_50M);
    #2 arst_n = 1'b1;
    ups = 1 + int'(next_random() % 4);
    downs = 1 + int'(next_random() % ups);
    reset_state();
    tone_alternation();
    speed_up_presses(ups);
    sample_strobe_spacing();
    speed_down_and_reset(downs);
    sample_strobe_spacing();
    assert_fails = i_simple_ipod_top.i_speed_control.i_simple_ipod_asserts.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/simple_ipod_pkg.sv
rtl/key_conditioner.sv
rtl/speed_control.sv
rtl/sample_clock_divider.sv
rtl/hex_display.sv
rtl/tone_generator.sv
rtl/simple_ipod_top.sv
verification/simple_ipod_asserts.sv
verification/simple_ipod_tb.sv
